//--- hdl/xge_settings.svh
// 10G packet path settings

`ifndef XGE_SETTINGS_SVH
`define XGE_SETTINGS_SVH

// Pad bytes in front of each client frame
`define XGE_PAD_BYTES 6

// Address width of the TX frame FIFO (512 beats)
`define XGE_TX_FIFO_AW 9

// Ingress label for the first pad byte
`define XGE_PORT_LABEL_DEFAULT 8'h00

`endif

//--- hdl/xge_pkg.sv
// Beat types for the 10G packet path

package xge_pkg;

  // Client tuser on RX output and TX input
  typedef struct packed {
    logic       err;
    logic [2:0] occ;
  } xge_rx_user_t;

  // Pad stripper to TX FIFO
  typedef struct packed {
    logic       sof;
    logic [2:0] occ;
  } xge_tx_user_t;

  typedef union packed {
    xge_rx_user_t rx_view;
    xge_tx_user_t tx_view;
  } xge_tuser_u;

  typedef struct packed {
    logic [63:0] tdata;
    xge_tuser_u  tuser;
    logic        tlast;
  } axis_beat_t;

  typedef struct packed {
    logic [63:0] data;
    logic [2:0]  mod;
    logic        sof;
    logic        eof;
    logic        err;
  } mac_beat_t;

  // Keeps the first nbytes bytes (byte 0 on top), zeroes the rest
  function automatic logic [63:0] xge_keep_bytes(input logic [63:0] data,
                                                 input logic [3:0]  nbytes);
    logic [63:0] mask;
    mask = ~({64{1'b1}} >> {nbytes, 3'b000});
    return data & mask;
  endfunction

endpackage

//--- hdl/xge_rx_reader.sv
// MAC RX read enable

`timescale 1ns/100ps

module xge_rx_reader (
  input  logic xgmii_clk,
  input  logic rst_n_i,
  input  logic rx_avail_i,
  input  logic rx_val_i,
  input  logic rx_eof_i,
  input  logic room_i,
  output logic rx_ren_o
);

  logic reading_q;
  logic eof_seen;

  assign eof_seen = rx_val_i && rx_eof_i;

  // Last beat already on the bus, so stop right here
  assign rx_ren_o = reading_q && room_i && !eof_seen;

  // Idle until a whole frame waits, read until its eof
  always_ff @(posedge xgmii_clk) begin
    if (!rst_n_i) begin
      reading_q <= 1'b0;
    end else if (!reading_q) begin
      reading_q <= rx_avail_i;
    end else if (eof_seen) begin
      reading_q <= 1'b0;
    end
  end

  a_no_ren_after_eof: assert property (@(posedge xgmii_clk) disable iff (!rst_n_i)
    eof_seen |=> !rx_ren_o);

endmodule

//--- hdl/xge_rx_pad_insert.sv
// RX pad insertion and output buffer

`timescale 1ns/100ps

`include "xge_settings.svh"

module xge_rx_pad_insert
  import xge_pkg::*;
#(
  parameter logic [7:0] PORT_LABEL = `XGE_PORT_LABEL_DEFAULT
) (
  input  logic       xgmii_clk,
  input  logic       rst_n_i,
  input  mac_beat_t  mac_i,
  input  logic       val_i,
  output axis_beat_t axis_o,
  output logic       valid_o,
  input  logic       ready_i,
  output logic       room_o
);

  localparam int PAD   = `XGE_PAD_BYTES;
  localparam int CARRY = 8 - PAD;

  // Trailing bytes of the previous MAC beat
  logic [PAD*8-1:0] carry_q;
  logic             in_frame_q;
  logic             tail_pend_q;
  logic [3:0]       tail_bytes_q;
  logic             tail_err_q;

  axis_beat_t buf_q [2];
  logic [1:0] count_q;
  logic       wr_ptr_q;
  logic       rd_ptr_q;

  logic [3:0]       n_bytes;
  logic [3:0]       end_bytes;
  logic             last_here;
  logic [PAD*8-1:0] hdr;
  logic [63:0]      body;
  axis_beat_t       main_beat;
  axis_beat_t       tail_beat;
  axis_beat_t       wr_beat;
  logic             tail_push;
  logic             push;
  logic             pop;

  //////////////////////////////
  // Beat forming
  //////////////////////////////

  always_comb begin
    n_bytes   = (mac_i.mod == 3'd0) ? 4'd8 : {1'b0, mac_i.mod};
    end_bytes = n_bytes + 4'(PAD);
    last_here = mac_i.eof && (n_bytes <= 4'(CARRY));
    // Label plus zero pad takes the carry's place on the first beat
    hdr  = in_frame_q ? carry_q : {PORT_LABEL, {(PAD-1)*8{1'b0}}};
    body = {hdr, mac_i.data[63 -: CARRY*8]};

    main_beat                   = '0;
    main_beat.tdata             = last_here ? xge_keep_bytes(body, end_bytes) : body;
    main_beat.tuser.rx_view.err = last_here && mac_i.err;
    main_beat.tuser.rx_view.occ = last_here ? end_bytes[2:0] : 3'd0;
    main_beat.tlast             = last_here;

    // Spill beat from the last carry
    tail_beat                   = '0;
    tail_beat.tdata             = xge_keep_bytes({carry_q, {CARRY*8{1'b0}}}, tail_bytes_q);
    tail_beat.tuser.rx_view.err = tail_err_q;
    tail_beat.tuser.rx_view.occ = tail_bytes_q[2:0];
    tail_beat.tlast             = 1'b1;
  end

  //////////////////////////////
  // Two entry output buffer
  //////////////////////////////

  assign pop       = valid_o && ready_i;
  assign tail_push = tail_pend_q && !val_i && (count_q != 2'd2);
  assign push      = val_i || tail_push;
  assign wr_beat   = val_i ? main_beat : tail_beat;
  assign valid_o   = (count_q != 2'd0);
  assign axis_o    = buf_q[rd_ptr_q];
  assign room_o    = (count_q == 2'd0) && !tail_pend_q;

  always_ff @(posedge xgmii_clk) begin
    if (!rst_n_i) begin
      in_frame_q  <= 1'b0;
      tail_pend_q <= 1'b0;
      count_q     <= 2'd0;
      wr_ptr_q    <= 1'b0;
      rd_ptr_q    <= 1'b0;
    end else begin
      if (val_i) begin
        in_frame_q <= !mac_i.eof;
      end
      if (val_i && mac_i.eof && !last_here) begin
        tail_pend_q <= 1'b1;
      end else if (tail_push) begin
        tail_pend_q <= 1'b0;
      end
      if (push) begin
        wr_ptr_q <= !wr_ptr_q;
      end
      if (pop) begin
        rd_ptr_q <= !rd_ptr_q;
      end
      count_q <= count_q + {1'b0, push} - {1'b0, pop};
    end
  end

  always_ff @(posedge xgmii_clk) begin
    if (val_i) begin
      carry_q      <= mac_i.data[PAD*8-1:0];
      tail_bytes_q <= n_bytes - 4'(CARRY);
      tail_err_q   <= mac_i.err;
    end
    if (push) begin
      buf_q[wr_ptr_q] <= wr_beat;
    end
  end

  // Reader only asks for a beat while this buffer is empty
  a_no_write_when_full: assert property (@(posedge xgmii_clk) disable iff (!rst_n_i)
    val_i |-> (count_q != 2'd2));

endmodule

//--- hdl/xge_tx_pad_strip.sv
// TX pad removal

`timescale 1ns/100ps

`include "xge_settings.svh"

module xge_tx_pad_strip
  import xge_pkg::*;
(
  input  logic       xgmii_clk,
  input  logic       rst_n_i,
  input  axis_beat_t s_axis_i,
  input  logic       s_valid_i,
  output logic       s_ready_o,
  output axis_beat_t m_axis_o,
  output logic       m_valid_o,
  input  logic       m_ready_i
);

  localparam int PAD   = `XGE_PAD_BYTES;
  localparam int CARRY = 8 - PAD;

  // Bytes 6 and 7 of the previous input beat
  logic [CARRY*8-1:0] carry_q;
  // Waiting for the padded first beat of a frame
  logic               hdr_q;
  logic               sof_q;
  logic               tail_pend_q;
  logic [3:0]         tail_bytes_q;
  axis_beat_t         m_q;
  logic               m_valid_q;

  logic        accept;
  logic [2:0]  in_occ;
  logic [3:0]  n_bytes;
  logic [3:0]  end_bytes;
  logic        last_here;
  logic [63:0] body;
  axis_beat_t  body_beat;
  axis_beat_t  tail_beat;

  // Whole stage advances only when the FIFO takes a beat
  assign s_ready_o = m_ready_i && !tail_pend_q;
  assign accept    = s_valid_i && s_ready_o;
  assign m_axis_o  = m_q;
  assign m_valid_o = m_valid_q;

  always_comb begin
    // Bit 3 of the client tuser is not looked at
    in_occ    = s_axis_i.tuser.rx_view.occ;
    n_bytes   = (in_occ == 3'd0) ? 4'd8 : {1'b0, in_occ};
    end_bytes = n_bytes + 4'(CARRY);
    last_here = s_axis_i.tlast && (n_bytes <= 4'(PAD));
    body      = {carry_q, s_axis_i.tdata[63 -: PAD*8]};

    body_beat                   = '0;
    body_beat.tdata             = last_here ? xge_keep_bytes(body, end_bytes) : body;
    body_beat.tuser.tx_view.sof = sof_q;
    body_beat.tuser.tx_view.occ = last_here ? end_bytes[2:0] : 3'd0;
    body_beat.tlast             = last_here;

    tail_beat                   = '0;
    tail_beat.tdata             = xge_keep_bytes({carry_q, {PAD*8{1'b0}}}, tail_bytes_q);
    tail_beat.tuser.tx_view.occ = tail_bytes_q[2:0];
    tail_beat.tlast             = 1'b1;
  end

  always_ff @(posedge xgmii_clk) begin
    if (!rst_n_i) begin
      hdr_q       <= 1'b1;
      sof_q       <= 1'b0;
      tail_pend_q <= 1'b0;
      m_valid_q   <= 1'b0;
    end else if (m_ready_i) begin
      // First input beat only loads the carry
      m_valid_q <= tail_pend_q || (accept && !hdr_q);
      if (tail_pend_q) begin
        tail_pend_q <= 1'b0;
      end
      if (accept) begin
        hdr_q       <= s_axis_i.tlast;
        sof_q       <= hdr_q;
        tail_pend_q <= !hdr_q && s_axis_i.tlast && !last_here;
      end
    end
  end

  always_ff @(posedge xgmii_clk) begin
    if (accept) begin
      carry_q      <= s_axis_i.tdata[CARRY*8-1:0];
      tail_bytes_q <= n_bytes - 4'(PAD);
    end
    if (m_ready_i) begin
      m_q <= tail_pend_q ? tail_beat : body_beat;
    end
  end

endmodule

//--- hdl/xge_tx_pkt_fifo.sv
// TX store and forward frame FIFO

`timescale 1ns/100ps

`include "xge_settings.svh"

module xge_tx_pkt_fifo
  import xge_pkg::*;
(
  input  logic       xgmii_clk,
  input  logic       rst_n_i,
  input  axis_beat_t s_axis_i,
  input  logic       s_valid_i,
  output logic       s_ready_o,
  output mac_beat_t  mac_o,
  output logic       val_o,
  input  logic       full_i
);

  localparam int AW    = `XGE_TX_FIFO_AW;
  localparam int DEPTH = 1 << AW;
  localparam logic [AW:0] FULL_LEVEL = {1'b1, {AW{1'b0}}};

  axis_beat_t    mem [DEPTH];
  logic [AW-1:0] wr_ptr_q;
  logic [AW-1:0] rd_ptr_q;
  logic [AW:0]   used_q;
  logic [AW:0]   used_next;
  // Whole frames held in the buffer
  logic [AW:0]   pkt_cnt_q;
  logic          s_ready_q;
  axis_beat_t    head;
  logic          wr;

  assign wr        = s_valid_i && s_ready_q;
  assign s_ready_o = s_ready_q;
  assign head      = mem[rd_ptr_q];

  // Nothing moves toward the MAC until a complete frame is stored
  assign val_o     = (pkt_cnt_q != '0) && !full_i;
  assign used_next = used_q + {{AW{1'b0}}, wr} - {{AW{1'b0}}, val_o};

  //////////////////////////////
  // MAC side mapping
  //////////////////////////////

  always_comb begin
    mac_o      = '0;
    mac_o.data = head.tdata;
    mac_o.mod  = head.tuser.tx_view.occ;
    mac_o.sof  = head.tuser.tx_view.sof;
    mac_o.eof  = head.tlast;
    mac_o.err  = 1'b0;
  end

  //////////////////////////////
  // Pointers and counts
  //////////////////////////////

  always_ff @(posedge xgmii_clk) begin
    if (!rst_n_i) begin
      wr_ptr_q  <= '0;
      rd_ptr_q  <= '0;
      used_q    <= '0;
      pkt_cnt_q <= '0;
      s_ready_q <= 1'b0;
    end else begin
      if (wr) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (val_o) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      used_q    <= used_next;
      s_ready_q <= (used_next != FULL_LEVEL);
      case ({wr && s_axis_i.tlast, val_o && head.tlast})
        2'b10:   pkt_cnt_q <= pkt_cnt_q + 1'b1;
        2'b01:   pkt_cnt_q <= pkt_cnt_q - 1'b1;
        default: pkt_cnt_q <= pkt_cnt_q;
      endcase
    end
  end

  always_ff @(posedge xgmii_clk) begin
    if (wr) begin
      mem[wr_ptr_q] <= s_axis_i;
    end
  end

  // Every counted frame still has its last beat in the buffer
  a_pkt_cnt_in_range: assert property (@(posedge xgmii_clk) disable iff (!rst_n_i)
    pkt_cnt_q <= used_q);

  // Equal pointers with data stored means no entry is free
  a_no_write_when_full: assert property (@(posedge xgmii_clk) disable iff (!rst_n_i)
    wr |-> !((wr_ptr_q == rd_ptr_q) && (used_q != '0)));

endmodule

//--- hdl/xge_packet_wrapper.sv
// 10G port packet path
// RX pad insertion and TX pad strip around the MAC packet FIFO

`timescale 1ns/100ps

`include "xge_settings.svh"

module xge_packet_wrapper
  import xge_pkg::*;
#(
  parameter logic [7:0] PORT_LABEL = `XGE_PORT_LABEL_DEFAULT
) (
  input  logic       xgmii_clk,
  input  logic       rst_n_i,
  // MAC RX packet side
  input  logic       rx_avail_i,
  input  logic       rx_val_i,
  input  mac_beat_t  rx_mac_i,
  output logic       rx_ren_o,
  // Client RX stream
  output axis_beat_t rx_axis_o,
  output logic       rx_valid_o,
  input  logic       rx_ready_i,
  // Client TX stream
  input  axis_beat_t tx_axis_i,
  input  logic       tx_valid_i,
  output logic       tx_ready_o,
  // MAC TX packet side
  output mac_beat_t  tx_mac_o,
  output logic       tx_val_o,
  input  logic       tx_full_i
);

  logic       rx_room;
  axis_beat_t tx_strip_beat;
  logic       tx_strip_valid;
  logic       tx_strip_ready;

  //////////////////////////////
  // RX chain
  //////////////////////////////

  xge_rx_reader xge_rx_reader_inst (
    .xgmii_clk  (xgmii_clk),
    .rst_n_i    (rst_n_i),
    .rx_avail_i (rx_avail_i),
    .rx_val_i   (rx_val_i),
    .rx_eof_i   (rx_mac_i.eof),
    .room_i     (rx_room),
    .rx_ren_o   (rx_ren_o)
  );

  xge_rx_pad_insert #(
    .PORT_LABEL (PORT_LABEL)
  ) xge_rx_pad_insert_inst (
    .xgmii_clk (xgmii_clk),
    .rst_n_i   (rst_n_i),
    .mac_i     (rx_mac_i),
    .val_i     (rx_val_i),
    .axis_o    (rx_axis_o),
    .valid_o   (rx_valid_o),
    .ready_i   (rx_ready_i),
    .room_o    (rx_room)
  );

  //////////////////////////////
  // TX chain
  //////////////////////////////

  xge_tx_pad_strip xge_tx_pad_strip_inst (
    .xgmii_clk (xgmii_clk),
    .rst_n_i   (rst_n_i),
    .s_axis_i  (tx_axis_i),
    .s_valid_i (tx_valid_i),
    .s_ready_o (tx_ready_o),
    .m_axis_o  (tx_strip_beat),
    .m_valid_o (tx_strip_valid),
    .m_ready_i (tx_strip_ready)
  );

  xge_tx_pkt_fifo xge_tx_pkt_fifo_inst (
    .xgmii_clk (xgmii_clk),
    .rst_n_i   (rst_n_i),
    .s_axis_i  (tx_strip_beat),
    .s_valid_i (tx_strip_valid),
    .s_ready_o (tx_strip_ready),
    .mac_o     (tx_mac_o),
    .val_o     (tx_val_o),
    .full_i    (tx_full_i)
  );

endmodule

//--- dv/xge_tb_table.svh
// Frame cases for the packet path testbench

`ifndef XGE_TB_TABLE_SVH
`define XGE_TB_TABLE_SVH

localparam int NUM_CASES = 24;

// Columns: length, dir (0 RX, 1 TX), err, stall, output beats, last occ
localparam case_t CASES [NUM_CASES] = '{
  // RX, one frame per length mod 8
  '{20, 1'b0, 1'b0, 1'b0, 4, 3'd2},
  '{21, 1'b0, 1'b0, 1'b0, 4, 3'd3},
  '{22, 1'b0, 1'b0, 1'b0, 4, 3'd4},
  '{23, 1'b0, 1'b0, 1'b0, 4, 3'd5},
  '{24, 1'b0, 1'b0, 1'b0, 4, 3'd6},
  '{25, 1'b0, 1'b0, 1'b0, 4, 3'd7},
  '{26, 1'b0, 1'b0, 1'b0, 4, 3'd0},
  '{27, 1'b0, 1'b0, 1'b0, 5, 3'd1},
  // RX error and back-pressure
  '{61, 1'b0, 1'b1, 1'b0, 9, 3'd3},
  '{70, 1'b0, 1'b0, 1'b1, 10, 3'd4},
  '{45, 1'b0, 1'b1, 1'b1, 7, 3'd3},
  '{58, 1'b0, 1'b0, 1'b1, 8, 3'd0},
  // TX, tail and no tail cases
  '{30, 1'b1, 1'b0, 1'b0, 4, 3'd6},
  '{31, 1'b1, 1'b0, 1'b0, 4, 3'd7},
  '{32, 1'b1, 1'b0, 1'b0, 4, 3'd0},
  '{33, 1'b1, 1'b0, 1'b0, 5, 3'd1},
  '{34, 1'b1, 1'b0, 1'b0, 5, 3'd2},
  '{35, 1'b1, 1'b0, 1'b0, 5, 3'd3},
  '{36, 1'b1, 1'b0, 1'b0, 5, 3'd4},
  '{37, 1'b1, 1'b0, 1'b0, 5, 3'd5},
  // TX with MAC full and client err bit
  '{64, 1'b1, 1'b0, 1'b1, 8, 3'd0},
  '{69, 1'b1, 1'b1, 1'b1, 9, 3'd5},
  '{50, 1'b1, 1'b1, 1'b0, 7, 3'd2},
  '{20, 1'b1, 1'b0, 1'b1, 3, 3'd4}
};

`endif

//--- dv/xge_packet_wrapper_tb.sv
// Packet path testbench

`timescale 1ns/100ps

`include "xge_settings.svh"

module xge_packet_wrapper_tb
  import xge_pkg::*;
();

  typedef struct packed {
    int         len;
    logic       dir;
    logic       err;
    logic       stall;
    int         beats;
    logic [2:0] occ;
  } case_t;

  `include "xge_tb_table.svh"

  localparam logic [7:0] LABEL   = 8'h5A;
  localparam int         TIMEOUT = 2000;

  logic        xgmii_clk;
  logic        rst_n_i;
  logic        rx_avail_i;
  logic        rx_val_i;
  mac_beat_t   rx_mac_i;
  logic        rx_ren_o;
  axis_beat_t  rx_axis_o;
  logic        rx_valid_o;
  logic        rx_ready_i;
  axis_beat_t  tx_axis_i;
  logic        tx_valid_i;
  logic        tx_ready_o;
  mac_beat_t   tx_mac_o;
  logic        tx_val_o;
  logic        tx_full_i;

  logic [31:0] rnd_state;
  int          err_count;
  int          timeout_count;
  int          check_count;

  xge_packet_wrapper #(
    .PORT_LABEL (LABEL)
  ) xge_packet_wrapper_inst (
    .xgmii_clk  (xgmii_clk),
    .rst_n_i    (rst_n_i),
    .rx_avail_i (rx_avail_i),
    .rx_val_i   (rx_val_i),
    .rx_mac_i   (rx_mac_i),
    .rx_ren_o   (rx_ren_o),
    .rx_axis_o  (rx_axis_o),
    .rx_valid_o (rx_valid_o),
    .rx_ready_i (rx_ready_i),
    .tx_axis_i  (tx_axis_i),
    .tx_valid_i (tx_valid_i),
    .tx_ready_o (tx_ready_o),
    .tx_mac_o   (tx_mac_o),
    .tx_val_o   (tx_val_o),
    .tx_full_i  (tx_full_i)
  );

  initial begin
    xgmii_clk = 1'b0;
    forever #10 xgmii_clk = ~xgmii_clk;
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    rnd_state = xorshift32(rnd_state);
    return rnd_state;
  endfunction

  // Eight bytes from first on, byte 0 on top, fill past the end
  function automatic logic [63:0] pack_beat(input logic [7:0] bytes [$], input int first,
                                            input logic [7:0] fill);
    logic [63:0] word;
    for (int i = 0; i < 8; i++) begin
      word[63 - 8*i -: 8] = (first + i < bytes.size()) ? bytes[first + i] : fill;
    end
    return word;
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("FAIL %s got %0h expected %0h", name, got, exp);
    end
  endtask

  //////////////////////////////
  // RX frame through MAC model
  //////////////////////////////

  task automatic receive_rx_frame(input case_t row, input int idx);
    mac_beat_t   mac_q [$];
    mac_beat_t   mb;
    axis_beat_t  got_q [$];
    logic [7:0]  frame_q [$];
    logic [7:0]  exp_q [$];
    logic [31:0] r;
    logic        ren_seen;
    logic        last;
    int          n_mac;
    int          sent;
    int          cycles;
    for (int i = 0; i < row.len; i++) begin
      r = next_rand();
      frame_q.push_back(r[7:0]);
    end
    // Label, zero pad, then the frame itself
    exp_q.push_back(LABEL);
    for (int i = 1; i < `XGE_PAD_BYTES; i++) begin
      exp_q.push_back(8'h00);
    end
    foreach (frame_q[i]) begin
      exp_q.push_back(frame_q[i]);
    end
    n_mac = (row.len + 7) / 8;
    for (int b = 0; b < n_mac; b++) begin
      last    = (b == n_mac - 1);
      mb      = '0;
      mb.data = pack_beat(frame_q, b * 8, 8'hEE);
      mb.mod  = last ? 3'(row.len % 8) : 3'd0;
      mb.sof  = (b == 0);
      mb.eof  = last;
      mb.err  = last && row.err;
      mac_q.push_back(mb);
    end
    sent   = 0;
    cycles = 0;
    @(posedge xgmii_clk);
    rx_avail_i <= 1'b1;
    rx_ready_i <= 1'b1;
    while (got_q.size() < row.beats && cycles < TIMEOUT) begin
      @(negedge xgmii_clk);
      if (rx_valid_o && rx_ready_i) begin
        got_q.push_back(rx_axis_o);
      end
      ren_seen = rx_ren_o;
      // No read request once the whole frame is out of the MAC
      check_value("rx_ren_o", 64'(ren_seen && sent >= n_mac), 64'(0));
      r        = next_rand();
      @(posedge xgmii_clk);
      // Beat follows the read enable by one cycle
      rx_val_i <= 1'b0;
      if (ren_seen && sent < n_mac) begin
        rx_mac_i <= mac_q[sent];
        rx_val_i <= 1'b1;
        sent++;
      end
      rx_avail_i <= (sent < n_mac);
      rx_ready_i <= row.stall ? r[0] : 1'b1;
      cycles++;
    end
    if (cycles >= TIMEOUT) begin
      timeout_count++;
      $display("ERROR case %0d: RX frame did not complete within %0d cycles", idx, TIMEOUT);
    end
    for (int b = 0; b < got_q.size(); b++) begin
      last = (b == row.beats - 1);
      check_value("rx_axis_o.tdata", got_q[b].tdata, pack_beat(exp_q, b * 8, 8'h00));
      check_value("rx_axis_o.tuser.err", 64'(got_q[b].tuser.rx_view.err), 64'(last && row.err));
      check_value("rx_axis_o.tuser.occ", 64'(got_q[b].tuser.rx_view.occ),
                  64'(last ? row.occ : 3'd0));
      check_value("rx_axis_o.tlast", 64'(got_q[b].tlast), 64'(last));
    end
  endtask

  //////////////////////////////
  // TX frame into MAC model
  //////////////////////////////

  task automatic send_tx_frame(input case_t row, input int idx);
    axis_beat_t  cli_q [$];
    axis_beat_t  cb;
    mac_beat_t   got_q [$];
    logic [7:0]  pad_q [$];
    logic [7:0]  exp_q [$];
    logic [31:0] r;
    logic        last;
    logic        last_done;
    int          n_cli;
    int          sent;
    int          cycles;
    for (int i = 0; i < `XGE_PAD_BYTES; i++) begin
      pad_q.push_back(8'hA0 + 8'(i));
    end
    for (int i = 0; i < row.len; i++) begin
      r = next_rand();
      pad_q.push_back(r[7:0]);
      exp_q.push_back(r[7:0]);
    end
    n_cli = (row.len + `XGE_PAD_BYTES + 7) / 8;
    for (int b = 0; b < n_cli; b++) begin
      last                    = (b == n_cli - 1);
      cb                      = '0;
      cb.tdata                = pack_beat(pad_q, b * 8, 8'hEE);
      cb.tuser.rx_view.err    = last && row.err;
      cb.tuser.rx_view.occ    = last ? 3'((row.len + `XGE_PAD_BYTES) % 8) : 3'd0;
      cb.tlast                = last;
      cli_q.push_back(cb);
    end
    sent      = 0;
    cycles    = 0;
    last_done = 1'b0;
    while (got_q.size() < row.beats && cycles < TIMEOUT) begin
      r = next_rand();
      @(posedge xgmii_clk);
      tx_valid_i <= (sent < n_cli);
      if (sent < n_cli) begin
        tx_axis_i <= cli_q[sent];
      end
      tx_full_i <= row.stall ? r[0] : 1'b0;
      @(negedge xgmii_clk);
      // Nothing may leave before the whole frame is stored
      check_value("tx_val_o", 64'(tx_val_o && !last_done), 64'(0));
      check_value("tx_val_o", 64'(tx_val_o && tx_full_i), 64'(0));
      if (tx_val_o) begin
        got_q.push_back(tx_mac_o);
      end
      if (tx_valid_i && tx_ready_o) begin
        last_done = cli_q[sent].tlast;
        sent++;
      end
      cycles++;
    end
    @(posedge xgmii_clk);
    tx_valid_i <= 1'b0;
    tx_full_i  <= 1'b0;
    if (cycles >= TIMEOUT) begin
      timeout_count++;
      $display("ERROR case %0d: TX frame did not reach the MAC within %0d cycles", idx, TIMEOUT);
    end
    for (int b = 0; b < got_q.size(); b++) begin
      last = (b == row.beats - 1);
      check_value("tx_mac_o.data", got_q[b].data, pack_beat(exp_q, b * 8, 8'h00));
      check_value("tx_mac_o.mod", 64'(got_q[b].mod), 64'(last ? row.occ : 3'd0));
      check_value("tx_mac_o.sof", 64'(got_q[b].sof), 64'(b == 0));
      check_value("tx_mac_o.eof", 64'(got_q[b].eof), 64'(last));
      check_value("tx_mac_o.err", 64'(got_q[b].err), 64'(0));
    end
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    rst_n_i       = 1'b0;
    rx_avail_i    = 1'b0;
    rx_val_i      = 1'b0;
    rx_mac_i      = '0;
    rx_ready_i    = 1'b1;
    tx_axis_i     = '0;
    tx_valid_i    = 1'b0;
    tx_full_i     = 1'b0;
    rnd_state     = 32'd1;
    err_count     = 0;
    timeout_count = 0;
    check_count   = 0;
    repeat (5) @(posedge xgmii_clk);
    rst_n_i <= 1'b1;
    for (int i = 0; i < NUM_CASES; i++) begin
      if (CASES[i].dir) begin
        send_tx_frame(CASES[i], i);
      end else begin
        receive_rx_frame(CASES[i], i);
      end
    end
    @(negedge xgmii_clk);
    // Both directions drained, no beat left over
    check_value("rx_valid_o", 64'(rx_valid_o), 64'(0));
    check_value("tx_val_o", 64'(tx_val_o), 64'(0));
    $display("Checks %0d, value errors %0d, timeouts %0d", check_count, err_count,
             timeout_count);
    if (err_count == 0 && timeout_count == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

//--- build.f
+incdir+hdl
+incdir+dv
hdl/xge_pkg.sv
hdl/xge_rx_reader.sv
hdl/xge_rx_pad_insert.sv
hdl/xge_tx_pad_strip.sv
hdl/xge_tx_pkt_fifo.sv
hdl/xge_packet_wrapper.sv
dv/xge_packet_wrapper_tb.sv

//--- run.sh
#!/bin/sh
# Compile and run the packet path testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module xge_packet_wrapper_tb -Mdir obj_dir -f build.f \
  || { echo "Verilator build failed"; exit 1; }

out=$(./obj_dir/Vxge_packet_wrapper_tb)
echo "$out"
echo "$out" | grep -qx "TEST PASS" && exit 0 || exit 1
